//--- Makefile
# Verilator build and run for the FP32 non-computational unit

VERILATOR := verilator
FLAGS     := --binary --timing --timescale 1ns/1ps -Wno-fatal
TOP       := tb_fpu_wrap
FILELIST  := fpu_wrap.f

OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST)) tb/fpu_vectors.svh

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- fpu_wrap.f
+incdir+tb
source/fpu_pkg.sv
source/fpu_decode.sv
source/fpu_issue_buffer.sv
source/fpu_noncomp.sv
source/fpu_result.sv
source/fpu_wrap.sv
tb/tb_fpu_wrap.sv

//--- source/fpu_decode.sv
// Opcode decoder
`timescale 1ns/1ps

module fpu_decode (
    input  fpu_pkg::fp_op_e              op_i,
    input  logic [2:0]                   rm_i,
    input  logic [fpu_pkg::FLEN-1:0]     operand_a_i,
    input  logic [fpu_pkg::FLEN-1:0]     operand_b_i,
    output fpu_pkg::fpu_req_t            req_o
);

    // ------------------------------
    // Operation translation
    // ------------------------------
    always_comb begin : p_decode
        // Operands pass through untouched
        req_o.operand_a = operand_a_i;
        req_o.operand_b = operand_b_i;
        req_o.op        = fpu_pkg::SGNJ;
        req_o.sub       = rm_i[1:0];  // rm MSB would select alt-half, FP32 only here

        unique case (op_i)
            fpu_pkg::FSGNJ: begin
                req_o.op  = fpu_pkg::SGNJ;  // j, jn, jx in rm
            end
            fpu_pkg::FMIN_MAX: begin
                req_o.op  = fpu_pkg::MINMAX;  // rm[0] picks max
            end
            fpu_pkg::FCMP: begin
                req_o.op  = fpu_pkg::CMP;  // le, lt, eq in rm
            end
            fpu_pkg::FCLASS: begin
                req_o.op  = fpu_pkg::CLASSIFY;
            end
            // Register moves need no recoding
            fpu_pkg::FMV_F2X,
            fpu_pkg::FMV_X2F: begin
                req_o.op  = fpu_pkg::SGNJ;
                req_o.sub = 2'd3;  // Passthrough of operand a
            end
            default: begin
                // Unknown opcode falls back to a plain move
                req_o.op  = fpu_pkg::SGNJ;
                req_o.sub = 2'd3;
            end
        endcase
    end

endmodule

//--- source/fpu_issue_buffer.sv
// Protocol inversion issue buffer
`timescale 1ns/1ps

module fpu_issue_buffer #(
    parameter int unsigned TagWidth = 3
) (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic                  flush_i,
    // Upstream
    input  logic                  in_valid_i,
    output logic                  in_ready_o,
    input  fpu_pkg::fpu_req_t     req_i,
    input  logic [TagWidth-1:0]   tag_i,
    // Toward execute
    output logic                  out_valid_o,
    input  logic                  out_ready_i,
    output fpu_pkg::fpu_req_t     req_o,
    output logic [TagWidth-1:0]   tag_o
);

    typedef enum logic {
        READY,
        STALL
    } state_e;

    state_e                state_q, state_d;
    logic                  hold_en;   // Capture request into hold register
    logic                  use_hold;  // Drive execute from hold register
    fpu_pkg::fpu_req_t     req_q;
    logic [TagWidth-1:0]   tag_q;

    // ------------------------------
    // Handshake FSM
    // ------------------------------
    always_comb begin : p_fsm
        in_ready_o  = 1'b0;
        out_valid_o = 1'b0;
        hold_en     = 1'b0;
        use_hold    = 1'b0;
        state_d     = state_q;

        unique case (state_q)
            READY: begin
                in_ready_o  = 1'b1;        // Look ready to issue
                out_valid_o = in_valid_i;  // Forward straight to execute
                // Execute refuses, so park the request
                if (in_valid_i && !out_ready_i) begin
                    in_ready_o = 1'b0;
                    hold_en    = 1'b1;
                    state_d    = STALL;
                end
            end
            STALL: begin
                out_valid_o = 1'b1;  // Held request pending
                use_hold    = 1'b1;
                if (out_ready_i) state_d = READY;  // Upstream released next cycle
            end
            default: state_d = READY;
        endcase

        // Flush drops any held request
        if (flush_i) state_d = READY;
    end

    // State register
    always_ff @(posedge clk_i or negedge rst_ni) begin : p_state
        if (!rst_ni) begin
            state_q <= READY;
        end else begin
            state_q <= state_d;
        end
    end

    // Hold register, payload only
    always_ff @(posedge clk_i) begin : p_hold
        if (hold_en) begin
            req_q <= req_i;
            tag_q <= tag_i;
        end
    end

    assign req_o = use_hold ? req_q : req_i;
    assign tag_o = use_hold ? tag_q : tag_i;

endmodule

//--- source/fpu_noncomp.sv
// FP32 non-computational execute stage
`timescale 1ns/1ps

module fpu_noncomp #(
    parameter int unsigned TagWidth = 3
) (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic                  flush_i,
    input  logic                  in_valid_i,
    output logic                  in_ready_o,
    input  fpu_pkg::fpu_req_t     req_i,
    input  logic [TagWidth-1:0]   tag_i,
    output logic                  out_valid_o,
    input  logic                  out_ready_i,
    output fpu_pkg::fpu_rsp_t     rsp_o,
    output logic [TagWidth-1:0]   tag_o
);

    localparam int unsigned FLEN = fpu_pkg::FLEN;

    // Per-operand class bits
    typedef struct packed {
        logic sign;
        logic zero;
        logic subnormal;
        logic inf;
        logic snan;
        logic qnan;
    } fp_class_t;

    function automatic fp_class_t classify_op(input logic [FLEN-1:0] x);
        logic [7:0]  exp_f;
        logic [22:0] man_f;
        fp_class_t   c;
        exp_f       = x[30:23];
        man_f       = x[22:0];
        c.sign      = x[FLEN-1];
        c.zero      = (exp_f == 8'h00) && (man_f == '0);
        c.subnormal = (exp_f == 8'h00) && (man_f != '0);
        c.inf       = (exp_f == 8'hff) && (man_f == '0);
        c.snan      = (exp_f == 8'hff) && (man_f != '0) && !man_f[22];
        c.qnan      = (exp_f == 8'hff) && man_f[22];  // Quiet bit set
        return c;
    endfunction

    logic                  valid_q;
    fpu_pkg::fpu_req_t     req_q;
    logic [TagWidth-1:0]   tag_q;
    fp_class_t             cls_a_q, cls_b_q;

    // ------------------------------
    // Stage register
    // ------------------------------
    assign in_ready_o = !valid_q || out_ready_i;  // Empty or draining

    always_ff @(posedge clk_i or negedge rst_ni) begin : p_valid
        if (!rst_ni) begin
            valid_q <= 1'b0;
        end else if (flush_i) begin
            valid_q <= 1'b0;
        end else if (in_ready_o) begin
            valid_q <= in_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin : p_data
        if (in_valid_i && in_ready_o) begin
            req_q   <= req_i;
            tag_q   <= tag_i;
            cls_a_q <= classify_op(req_i.operand_a);
            cls_b_q <= classify_op(req_i.operand_b);
        end
    end

    // ------------------------------
    // Ordering helpers
    // ------------------------------
    logic a_nan, b_nan, any_snan;
    logic both_zero;
    logic lt_total;  // a < b with -0 below +0, NaN-free inputs

    assign a_nan     = cls_a_q.snan | cls_a_q.qnan;
    assign b_nan     = cls_b_q.snan | cls_b_q.qnan;
    assign any_snan  = cls_a_q.snan | cls_b_q.snan;
    assign both_zero = cls_a_q.zero & cls_b_q.zero;

    always_comb begin : p_order
        if (cls_a_q.sign != cls_b_q.sign) begin
            lt_total = cls_a_q.sign;  // Negative one is smaller
        end else if (!cls_a_q.sign) begin
            lt_total = req_q.operand_a[30:0] < req_q.operand_b[30:0];
        end else begin
            lt_total = req_q.operand_a[30:0] > req_q.operand_b[30:0];  // Magnitude reversed
        end
    end

    // ------------------------------
    // Result and flags
    // ------------------------------
    logic        cmp_lt, cmp_eq;
    logic [9:0]  cls_mask;

    assign cmp_lt = lt_total && !both_zero;  // +0 and -0 compare equal
    assign cmp_eq = (req_q.operand_a == req_q.operand_b) || both_zero;

    // One-hot class of operand a
    assign cls_mask[fpu_pkg::CLS_NEG_INF]  = cls_a_q.sign & cls_a_q.inf;
    assign cls_mask[fpu_pkg::CLS_NEG_NORM] = cls_a_q.sign & ~cls_a_q.zero & ~cls_a_q.subnormal
                                           & ~cls_a_q.inf & ~a_nan;
    assign cls_mask[fpu_pkg::CLS_NEG_SUBN] = cls_a_q.sign & cls_a_q.subnormal;
    assign cls_mask[fpu_pkg::CLS_NEG_ZERO] = cls_a_q.sign & cls_a_q.zero;
    assign cls_mask[fpu_pkg::CLS_POS_ZERO] = ~cls_a_q.sign & cls_a_q.zero;
    assign cls_mask[fpu_pkg::CLS_POS_SUBN] = ~cls_a_q.sign & cls_a_q.subnormal;
    assign cls_mask[fpu_pkg::CLS_POS_NORM] = ~cls_a_q.sign & ~cls_a_q.zero & ~cls_a_q.subnormal
                                           & ~cls_a_q.inf & ~a_nan;
    assign cls_mask[fpu_pkg::CLS_POS_INF]  = ~cls_a_q.sign & cls_a_q.inf;
    assign cls_mask[fpu_pkg::CLS_SNAN]     = cls_a_q.snan;
    assign cls_mask[fpu_pkg::CLS_QNAN]     = cls_a_q.qnan;

    always_comb begin : p_exec
        rsp_o.result = req_q.operand_a;
        rsp_o.status = '0;

        unique case (req_q.op)
            fpu_pkg::SGNJ: begin
                unique case (req_q.sub)
                    2'd0:    rsp_o.result = {cls_b_q.sign, req_q.operand_a[30:0]};
                    2'd1:    rsp_o.result = {~cls_b_q.sign, req_q.operand_a[30:0]};
                    2'd2:    rsp_o.result = {cls_a_q.sign ^ cls_b_q.sign,
                                             req_q.operand_a[30:0]};
                    default: rsp_o.result = req_q.operand_a;  // Move
                endcase
            end
            fpu_pkg::MINMAX: begin
                rsp_o.status.nv = any_snan;
                if (a_nan && b_nan) begin
                    rsp_o.result = fpu_pkg::CANONICAL_NAN;
                end else if (a_nan) begin
                    rsp_o.result = req_q.operand_b;  // Non-NaN operand wins
                end else if (b_nan) begin
                    rsp_o.result = req_q.operand_a;
                end else if (req_q.sub[0] ^ lt_total) begin
                    rsp_o.result = req_q.operand_a;  // min and a<b, or max and a>=b
                end else begin
                    rsp_o.result = req_q.operand_b;
                end
            end
            fpu_pkg::CMP: begin
                rsp_o.result = '0;
                unique case (req_q.sub)
                    2'd0: begin  // le
                        rsp_o.result[0] = !(a_nan || b_nan) && (cmp_lt || cmp_eq);
                        rsp_o.status.nv = a_nan || b_nan;
                    end
                    2'd1: begin  // lt
                        rsp_o.result[0] = !(a_nan || b_nan) && cmp_lt;
                        rsp_o.status.nv = a_nan || b_nan;
                    end
                    2'd2: begin  // eq, quiet on qNaN
                        rsp_o.result[0] = !(a_nan || b_nan) && cmp_eq;
                        rsp_o.status.nv = any_snan;
                    end
                    default: ;  // Always false
                endcase
            end
            fpu_pkg::CLASSIFY: begin
                rsp_o.result = {{(FLEN-10){1'b0}}, cls_mask};
            end
            default: ;
        endcase
    end

    assign out_valid_o = valid_q;
    assign tag_o       = tag_q;

endmodule

//--- source/fpu_pkg.sv
// FP32 non-computational unit definitions
package fpu_pkg;

    // ------------------------------
    // Widths
    // ------------------------------
    localparam int unsigned FLEN  = 32;  // FP32 only
    localparam int unsigned SUB_W = 2;   // Sub-operation field

    // Front-end opcodes, as sent by the issue stage
    typedef enum logic [2:0] {
        FSGNJ    = 3'd0,
        FMIN_MAX = 3'd1,
        FCMP     = 3'd2,
        FCLASS   = 3'd3,
        FMV_F2X  = 3'd4,
        FMV_X2F  = 3'd5
    } fp_op_e;

    // Operations of the execute unit
    typedef enum logic [1:0] {
        SGNJ     = 2'd0,
        MINMAX   = 2'd1,
        CMP      = 2'd2,
        CLASSIFY = 2'd3
    } unit_op_e;

    // IEEE status flags, only nv is produced here
    typedef struct packed {
        logic nv;  // Invalid operation
        logic dz;  // Divide by zero
        logic of;  // Overflow
        logic uf;  // Underflow
        logic nx;  // Inexact
    } status_t;

    // ------------------------------
    // Request and response
    // ------------------------------
    typedef struct packed {
        unit_op_e             op;
        logic [SUB_W-1:0]     sub;        // Taken from rm[1:0]
        logic [FLEN-1:0]      operand_a;
        logic [FLEN-1:0]      operand_b;
    } fpu_req_t;

    typedef struct packed {
        logic [FLEN-1:0] result;
        status_t         status;
    } fpu_rsp_t;

    // Quiet NaN returned when both min/max operands are NaN
    localparam logic [FLEN-1:0] CANONICAL_NAN = 32'h7fc00000;

    // Bit positions of the classify mask
    localparam int unsigned CLS_NEG_INF    = 0;
    localparam int unsigned CLS_NEG_NORM   = 1;
    localparam int unsigned CLS_NEG_SUBN   = 2;
    localparam int unsigned CLS_NEG_ZERO   = 3;
    localparam int unsigned CLS_POS_ZERO   = 4;
    localparam int unsigned CLS_POS_SUBN   = 5;
    localparam int unsigned CLS_POS_NORM   = 6;
    localparam int unsigned CLS_POS_INF    = 7;
    localparam int unsigned CLS_SNAN       = 8;
    localparam int unsigned CLS_QNAN       = 9;

endpackage

//--- source/fpu_result.sv
// Output register toward writeback
`timescale 1ns/1ps

module fpu_result #(
    parameter int unsigned TagWidth = 3
) (
    input  logic                         clk_i,
    input  logic                         rst_ni,
    input  logic                         flush_i,
    input  logic                         in_valid_i,
    output logic                         in_ready_o,
    input  fpu_pkg::fpu_rsp_t            rsp_i,
    input  logic [TagWidth-1:0]          tag_i,
    output logic                         result_valid_o,
    input  logic                         result_ready_i,
    output logic [fpu_pkg::FLEN-1:0]     result_o,
    output fpu_pkg::status_t             status_o,
    output logic [TagWidth-1:0]          tag_o
);

    logic                  valid_q;
    fpu_pkg::fpu_rsp_t     rsp_q;
    logic [TagWidth-1:0]   tag_q;

    // Accept when empty or the held result leaves this cycle
    assign in_ready_o = !valid_q || result_ready_i;

    always_ff @(posedge clk_i or negedge rst_ni) begin : p_valid
        if (!rst_ni) begin
            valid_q <= 1'b0;
        end else if (flush_i) begin
            valid_q <= 1'b0;
        end else if (in_ready_o) begin
            valid_q <= in_valid_i;
        end
    end

    // Payload holds under back-pressure
    always_ff @(posedge clk_i) begin : p_data
        if (in_valid_i && in_ready_o) begin
            rsp_q <= rsp_i;
            tag_q <= tag_i;
        end
    end

    assign result_valid_o = valid_q;
    assign result_o       = rsp_q.result;
    assign status_o       = rsp_q.status;
    assign tag_o          = tag_q;

endmodule

//--- source/fpu_wrap.sv
// FP32 non-computational unit top level
`timescale 1ns/1ps

module fpu_wrap #(
    parameter int unsigned TagWidth = 3
) (
    input  logic                         clk_i,
    input  logic                         rst_ni,
    input  logic                         flush_i,
    // Issue side
    input  logic                         fpu_valid_i,
    output logic                         fpu_ready_o,
    input  fpu_pkg::fp_op_e              op_i,
    input  logic [2:0]                   rm_i,
    input  logic [fpu_pkg::FLEN-1:0]     operand_a_i,
    input  logic [fpu_pkg::FLEN-1:0]     operand_b_i,
    input  logic [TagWidth-1:0]          tag_i,
    // Writeback side
    output logic                         result_valid_o,
    input  logic                         result_ready_i,
    output logic [fpu_pkg::FLEN-1:0]     result_o,
    output fpu_pkg::status_t             status_o,
    output logic [TagWidth-1:0]          tag_o
);

    // ------------------------------
    // Internal links
    // ------------------------------
    fpu_pkg::fpu_req_t     dec_req;
    logic                  issue_valid, issue_ready;
    fpu_pkg::fpu_req_t     issue_req;
    logic [TagWidth-1:0]   issue_tag;
    logic                  exe_valid, exe_ready;
    fpu_pkg::fpu_rsp_t     exe_rsp;
    logic [TagWidth-1:0]   exe_tag;

    fpu_decode i_decode (
        .op_i        (op_i),
        .rm_i        (rm_i),
        .operand_a_i (operand_a_i),
        .operand_b_i (operand_b_i),
        .req_o       (dec_req)
    );

    // Holds one request while execute is full
    fpu_issue_buffer #(
        .TagWidth (TagWidth)
    ) i_issue_buffer (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .flush_i     (flush_i),
        .in_valid_i  (fpu_valid_i),
        .in_ready_o  (fpu_ready_o),
        .req_i       (dec_req),
        .tag_i       (tag_i),
        .out_valid_o (issue_valid),
        .out_ready_i (issue_ready),
        .req_o       (issue_req),
        .tag_o       (issue_tag)
    );

    fpu_noncomp #(
        .TagWidth (TagWidth)
    ) i_noncomp (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .flush_i     (flush_i),
        .in_valid_i  (issue_valid),
        .in_ready_o  (issue_ready),
        .req_i       (issue_req),
        .tag_i       (issue_tag),
        .out_valid_o (exe_valid),
        .out_ready_i (exe_ready),
        .rsp_o       (exe_rsp),
        .tag_o       (exe_tag)
    );

    fpu_result #(
        .TagWidth (TagWidth)
    ) i_result (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .flush_i        (flush_i),
        .in_valid_i     (exe_valid),
        .in_ready_o     (exe_ready),
        .rsp_i          (exe_rsp),
        .tag_i          (exe_tag),
        .result_valid_o (result_valid_o),
        .result_ready_i (result_ready_i),
        .result_o       (result_o),
        .status_o       (status_o),
        .tag_o          (tag_o)
    );

endmodule

//--- tb/fpu_vectors.svh
// Directed stimulus table
`ifndef FPU_VECTORS_SVH
`define FPU_VECTORS_SVH

// Columns are opcode, rm, operand a, operand b, expected result and expected nv
typedef struct packed {
    fpu_pkg::fp_op_e op;
    logic [2:0]      rm;   // rm[1:0] is the sub-operation
    logic [31:0]     a;
    logic [31:0]     b;
    logic [31:0]     res;
    logic            nv;   // Only flag the unit raises
} stim_t;

// ------------------------------
// FP32 encodings
// ------------------------------
localparam logic [31:0] P_ZERO = 32'h00000000;
localparam logic [31:0] N_ZERO = 32'h80000000;
localparam logic [31:0] P_ONE  = 32'h3f800000;
localparam logic [31:0] N_ONE  = 32'hbf800000;
localparam logic [31:0] P_TWO  = 32'h40000000;
localparam logic [31:0] N_TWO  = 32'hc0000000;
localparam logic [31:0] P_INF  = 32'h7f800000;
localparam logic [31:0] N_INF  = 32'hff800000;
localparam logic [31:0] P_SUB  = 32'h00000001;  // Smallest subnormal
localparam logic [31:0] N_SUB  = 32'h80000001;
localparam logic [31:0] QNAN   = 32'h7fc00000;
localparam logic [31:0] N_QNAN = 32'hffc00001;  // Negative quiet NaN with payload
localparam logic [31:0] SNAN   = 32'h7f800001;  // Quiet bit clear

localparam int NUM_VECTORS = 32;

localparam stim_t VEC_TABLE [NUM_VECTORS] = '{
    // Min/max with rm[0] picking max
    '{fpu_pkg::FMIN_MAX, 3'd0, P_ZERO, N_ZERO, N_ZERO, 1'b0},  // -0 below +0
    '{fpu_pkg::FMIN_MAX, 3'd1, P_ZERO, N_ZERO, P_ZERO, 1'b0},
    '{fpu_pkg::FMIN_MAX, 3'd0, P_ONE,  QNAN,   P_ONE,  1'b0},  // One NaN
    '{fpu_pkg::FMIN_MAX, 3'd1, QNAN,   N_ONE,  N_ONE,  1'b0},
    '{fpu_pkg::FMIN_MAX, 3'd0, N_QNAN, N_QNAN, QNAN,   1'b0},  // Canonical NaN
    '{fpu_pkg::FMIN_MAX, 3'd1, SNAN,   P_TWO,  P_TWO,  1'b1},
    '{fpu_pkg::FMIN_MAX, 3'd0, N_ONE,  P_TWO,  N_ONE,  1'b0},
    '{fpu_pkg::FMIN_MAX, 3'd1, N_ONE,  N_TWO,  N_ONE,  1'b0},
    '{fpu_pkg::FMIN_MAX, 3'd0, SNAN,   QNAN,   QNAN,   1'b1},
    '{fpu_pkg::FMIN_MAX, 3'd4, P_TWO,  N_TWO,  N_TWO,  1'b0},  // rm MSB ignored
    // Compare le, lt, eq and the never-true case
    '{fpu_pkg::FCMP,     3'd0, P_ONE,  P_TWO,  32'd1,  1'b0},
    '{fpu_pkg::FCMP,     3'd1, P_TWO,  P_ONE,  32'd0,  1'b0},
    '{fpu_pkg::FCMP,     3'd2, P_ZERO, N_ZERO, 32'd1,  1'b0},
    '{fpu_pkg::FCMP,     3'd1, N_ZERO, P_ZERO, 32'd0,  1'b0},
    '{fpu_pkg::FCMP,     3'd0, N_ZERO, P_ZERO, 32'd1,  1'b0},
    '{fpu_pkg::FCMP,     3'd2, QNAN,   P_ONE,  32'd0,  1'b0},  // Quiet eq
    '{fpu_pkg::FCMP,     3'd2, SNAN,   P_ONE,  32'd0,  1'b1},
    '{fpu_pkg::FCMP,     3'd0, QNAN,   P_ONE,  32'd0,  1'b1},  // Signaling le
    '{fpu_pkg::FCMP,     3'd1, P_ONE,  SNAN,   32'd0,  1'b1},
    '{fpu_pkg::FCMP,     3'd3, P_ONE,  P_ONE,  32'd0,  1'b0},
    '{fpu_pkg::FCMP,     3'd2, N_TWO,  N_TWO,  32'd1,  1'b0},
    '{fpu_pkg::FCMP,     3'd1, N_TWO,  N_ONE,  32'd1,  1'b0},
    // Classify with one entry per class
    '{fpu_pkg::FCLASS,   3'd0, N_INF,  P_ZERO, 32'h001, 1'b0},
    '{fpu_pkg::FCLASS,   3'd0, N_ONE,  P_ZERO, 32'h002, 1'b0},
    '{fpu_pkg::FCLASS,   3'd0, N_SUB,  P_ZERO, 32'h004, 1'b0},
    '{fpu_pkg::FCLASS,   3'd0, N_ZERO, P_ZERO, 32'h008, 1'b0},
    '{fpu_pkg::FCLASS,   3'd0, P_ZERO, P_ZERO, 32'h010, 1'b0},
    '{fpu_pkg::FCLASS,   3'd0, P_SUB,  P_ZERO, 32'h020, 1'b0},
    '{fpu_pkg::FCLASS,   3'd0, P_ONE,  P_ZERO, 32'h040, 1'b0},
    '{fpu_pkg::FCLASS,   3'd0, P_INF,  P_ZERO, 32'h080, 1'b0},
    '{fpu_pkg::FCLASS,   3'd0, SNAN,   P_ZERO, 32'h100, 1'b0},
    '{fpu_pkg::FCLASS,   3'd0, QNAN,   P_ZERO, 32'h200, 1'b0}
};

`endif

//--- tb/tb_fpu_wrap.sv
// FP32 non-computational unit testbench
`timescale 1ns/1ps

module tb_fpu_wrap;

    `include "fpu_vectors.svh"

    localparam int CLK_PERIOD     = 4;
    localparam int RAND_COUNT     = 40;  // Random sign-injection and move requests
    localparam int TIMEOUT_CYCLES = (NUM_VECTORS + RAND_COUNT) * 20;

    // Expected response queued in issue order
    typedef struct packed {
        logic [31:0] res;
        logic        nv;
        logic [2:0]  tag;
    } exp_t;

    logic               clk_i;
    logic               rst_ni;
    logic               flush_i;
    logic               fpu_valid_i;
    logic               fpu_ready_o;
    fpu_pkg::fp_op_e    op_i;
    logic [2:0]         rm_i;
    logic [31:0]        operand_a_i;
    logic [31:0]        operand_b_i;
    logic [2:0]         tag_i;
    logic               result_valid_o;
    logic               result_ready_i;
    logic [31:0]        result_o;
    fpu_pkg::status_t   status_o;
    logic [2:0]         tag_o;

    stim_t       stim_q[$];
    exp_t        exp_q[$];
    logic [31:0] lcg_state = 32'h6e3f;
    int          issued    = 0;
    int          completed = 0;

    fpu_wrap #(
        .TagWidth (3)
    ) dut_i (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .flush_i        (flush_i),
        .fpu_valid_i    (fpu_valid_i),
        .fpu_ready_o    (fpu_ready_o),
        .op_i           (op_i),
        .rm_i           (rm_i),
        .operand_a_i    (operand_a_i),
        .operand_b_i    (operand_b_i),
        .tag_i          (tag_i),
        .result_valid_o (result_valid_o),
        .result_ready_i (result_ready_i),
        .result_o       (result_o),
        .status_o       (status_o),
        .tag_o          (tag_o)
    );

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    // ------------------------------
    // Helpers
    // ------------------------------
    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Sign injection and moves from the opcode rules
    function automatic logic [31:0] sgnj_expect(input fpu_pkg::fp_op_e op,
                                                input logic [2:0] rm,
                                                input logic [31:0] a, input logic [31:0] b);
        if (op != fpu_pkg::FSGNJ) return a;  // Both moves copy a
        case (rm[1:0])
            2'd0:    return {b[31], a[30:0]};
            2'd1:    return {~b[31], a[30:0]};
            2'd2:    return {a[31] ^ b[31], a[30:0]};
            default: return a;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got 0x%08h, expected 0x%08h", name, got, exp);
            $display("SIMULATION FAILED");
            $fatal(1);
        end
    endtask

    // Table followed by random sign-injection traffic
    task automatic build_stimulus();
        stim_t       s;
        logic [31:0] r;
        for (int i = 0; i < NUM_VECTORS; i++) stim_q.push_back(VEC_TABLE[i]);
        for (int i = 0; i < RAND_COUNT; i++) begin
            r = next_random();
            case (r[17:16])
                2'd2:    s.op = fpu_pkg::FMV_F2X;
                2'd3:    s.op = fpu_pkg::FMV_X2F;
                default: s.op = fpu_pkg::FSGNJ;
            endcase
            s.rm  = r[20:18];
            s.a   = next_random();
            s.b   = next_random();
            s.res = sgnj_expect(s.op, s.rm, s.a, s.b);
            s.nv  = 1'b0;
            stim_q.push_back(s);
        end
    endtask

    // Pop the oldest expectation and compare
    task automatic collect_result();
        exp_t e;
        if (exp_q.size() == 0) begin
            $display("ERROR: result_valid_o rose with no request outstanding");
            $display("SIMULATION FAILED");
            $fatal(1);
        end else begin
            e = exp_q.pop_front();
            check_value("result_o", result_o, e.res);
            check_value("status_o", 32'(status_o), 32'({e.nv, 4'b0000}));
            check_value("tag_o", 32'(tag_o), 32'(e.tag));
            completed++;
        end
    endtask

    // One clock cycle of stimulus starting at the falling edge
    task automatic drive_cycle(input bit have_req, input stim_t s, input int idx,
                               input logic rdy, input logic flush, output bit taken);
        exp_t e;
        @(negedge clk_i);
        result_ready_i = rdy;
        flush_i        = flush;
        fpu_valid_i    = 1'b0;
        #0.5;
        taken = have_req && fpu_ready_o && !flush;  // Low ready with valid low means STALL
        if (taken) begin
            op_i        = s.op;
            rm_i        = s.rm;
            operand_a_i = s.a;
            operand_b_i = s.b;
            tag_i       = idx[2:0];
            fpu_valid_i = 1'b1;
            e.res = s.res;
            e.nv  = s.nv;
            e.tag = idx[2:0];
            exp_q.push_back(e);
            issued++;
        end
        #0.5;
        if (fpu_valid_i && !fpu_ready_o) begin
            // Ready may only fall while writeback blocks
            check_value("result_valid_o", 32'(result_valid_o), 32'd1);
            check_value("result_ready_i", 32'(result_ready_i), 32'd0);
        end
        if (result_valid_o && result_ready_i) collect_result();  // Transfers at next edge
    endtask

    task automatic drain(input int max_cycles);
        bit          taken;
        logic [31:0] r;
        for (int i = 0; i < max_cycles && exp_q.size() != 0; i++) begin
            r = next_random();
            drive_cycle(1'b0, stim_q[0], 0, r[17:16] != 2'b00, 1'b0, taken);
        end
    endtask

    task automatic check_idle();
        @(negedge clk_i);
        flush_i        = 1'b0;
        fpu_valid_i    = 1'b0;
        result_ready_i = 1'b0;
        #0.5;
        check_value("fpu_ready_o", 32'(fpu_ready_o), 32'd1);
        check_value("result_valid_o", 32'(result_valid_o), 32'd0);
    endtask

    // ------------------------------
    // Main sequence
    // ------------------------------
    initial begin : p_main
        bit          taken;
        int          idx;
        logic [31:0] r;
        clk_i          = 1'b0;
        rst_ni         = 1'b0;
        flush_i        = 1'b0;
        fpu_valid_i    = 1'b0;
        op_i           = fpu_pkg::FSGNJ;
        rm_i           = 3'd0;
        operand_a_i    = '0;
        operand_b_i    = '0;
        tag_i          = '0;
        result_ready_i = 1'b0;
        build_stimulus();

        repeat (4) @(posedge clk_i);
        @(negedge clk_i);
        rst_ni = 1'b1;
        check_idle();  // Reset state

        // Full stream under random back-pressure
        idx = 0;
        while (idx < stim_q.size()) begin
            r = next_random();
            drive_cycle(1'b1, stim_q[idx], idx, r[17:16] != 2'b00, 1'b0, taken);
            if (taken) idx++;
        end
        drain(TIMEOUT_CYCLES);

        // Fill execute, result and hold register with writeback blocked
        idx = 0;
        for (int i = 0; i < 5; i++) begin
            drive_cycle(1'b1, stim_q[idx], idx, 1'b0, 1'b0, taken);
            if (taken) idx++;
        end
        check_value("fpu_ready_o", 32'(fpu_ready_o), 32'd0);
        drive_cycle(1'b0, stim_q[0], 0, 1'b0, 1'b1, taken);
        issued = issued - exp_q.size();  // Flushed requests never return
        exp_q.delete();
        check_idle();

        // Traffic after the flush
        idx = 0;
        while (idx < 12) begin
            r = next_random();
            drive_cycle(1'b1, stim_q[idx], idx, r[17:16] != 2'b00, 1'b0, taken);
            if (taken) idx++;
        end
        drain(TIMEOUT_CYCLES);
        check_idle();  // No extra result left behind

        if (exp_q.size() == 0 && completed == issued) begin
            $display("SIMULATION PASSED");
            $finish;
        end else begin
            $display("ERROR: %0d of %0d responses never arrived", issued - completed, issued);
            $display("SIMULATION FAILED");
            $fatal(1);
        end
    end

    // Watchdog
    initial begin : p_watchdog
        repeat (TIMEOUT_CYCLES) @(posedge clk_i);
        $display("ERROR: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("SIMULATION FAILED");
        $fatal(1);
    end

endmodule
